//--- fake_sensor.f
fake_sensor_pkg.sv
i2c_bus_decode.sv
i2c_txn_execute.sv
sensor_reg_result.sv
fake_sensor_top.sv
fake_sensor_props.sv
tb_fake_sensor.sv

//--- fake_sensor_pkg.sv
// Shared constants and types for the fake camera-sensor I2C target.
// Register addresses are 16 bits wide and arrive high byte first.
// The device address always sits in the low 7 bits of register 0.
// Unmapped reads return READ_MISS_VAL and writes to them are dropped.
package fake_sensor_pkg;

	localparam int REG_ADDR_W = 16; // register pointer width
	localparam int DATA_W     = 8;
	localparam int DEV_ADDR_W = 7;

	localparam logic [REG_ADDR_W-1:0] REG_DEV_ADDR = 16'h0000;
	localparam logic [REG_ADDR_W-1:0] REG_ID_BASE  = 16'h0001;
	localparam logic [REG_ADDR_W-1:0] REG_ID_COUNT = 16'd4;
	localparam logic [DATA_W-1:0]     REG_ID_VAL   = 8'hA0; // first identity value
	localparam logic [REG_ADDR_W-1:0] REG_RW_BASE  = 16'h0005;
	localparam logic [REG_ADDR_W-1:0] REG_RW_COUNT = 16'd8;
	localparam logic [DATA_W-1:0]     REG_RW_RESET = 8'hB0; // reset value of first rw byte

	// fixed registers at the real sensor's addresses
	localparam int SENSOR_REG_COUNT = 10;
	localparam logic [REG_ADDR_W-1:0] SENSOR_REG_ADDR [SENSOR_REG_COUNT] = '{
		16'h3000, 16'h3001, 16'h300E, 16'h300F, 16'h3364,
		16'h3365, 16'h3E18, 16'h3E19, 16'h3E9A, 16'h3E9B
	};
	localparam logic [DATA_W-1:0] SENSOR_REG_VAL [SENSOR_REG_COUNT] = '{
		8'h09, 8'h56, 8'h20, 8'h2E, 8'h06,
		8'hD5, 8'h0F, 8'h2A, 8'h04, 8'hF7
	};

	localparam logic [DATA_W-1:0] READ_MISS_VAL = 8'hFF;

	typedef enum logic [2:0] {IDLE, CTRL, ADDR_HI, ADDR_LO, WRITE, READ, WAIT_STOP} txn_state_e;

	typedef enum logic {DIR_WRITE = 1'b0, DIR_READ = 1'b1} i2c_dir_e;

	typedef struct packed {
		logic              start;     // start or repeated start
		logic              stop;
		logic              scl_fall;
		logic              byte_done; // 8th scl rise
		logic              ack_bit;   // sda at 9th rise
		logic              ack_valid;
		logic [DATA_W-1:0] rx_byte;   // holds until next byte
	} bus_evt_t;

	typedef struct packed {
		logic                  cyc;
		logic                  stb;
		logic                  we;
		logic [REG_ADDR_W-1:0] adr;
		logic [DATA_W-1:0]     dat;
	} wb_req_t;

	typedef struct packed {
		logic              ack;
		logic [DATA_W-1:0] dat;
	} wb_rsp_t;

endpackage

//--- fake_sensor_props.sv
// Protocol properties of the transaction engine, bound into every
// i2c_txn_execute instance. Checked only while rst_n is high.
`timescale 1ns/1ps
module fake_sensor_props (
	input logic                        sys_clk,
	input logic                        rst_n,
	input fake_sensor_pkg::txn_state_e state_i,
	input fake_sensor_pkg::bus_evt_t   evt_i,
	input fake_sensor_pkg::wb_req_t    wb_req_i,
	input fake_sensor_pkg::wb_rsp_t    wb_rsp_i,
	input logic                        sda_oe_i
);

	// slave may only answer a strobe that is still up
	a_ack_in_stb: assert property (@(posedge sys_clk) disable iff (!rst_n)
		wb_rsp_i.ack |-> wb_req_i.stb)
		else $error("wishbone ack without a pending stb");

	a_stb_until_ack: assert property (@(posedge sys_clk) disable iff (!rst_n)
		(wb_req_i.stb && !wb_rsp_i.ack) |=> wb_req_i.stb)
		else $error("wishbone stb dropped before ack");

	// target must leave the line alone between transactions
	a_idle_released: assert property (@(posedge sys_clk) disable iff (!rst_n)
		(state_i == fake_sensor_pkg::IDLE) |-> !sda_oe_i)
		else $error("sda pulled low while idle");

	a_stop_to_idle: assert property (@(posedge sys_clk) disable iff (!rst_n)
		evt_i.stop |=> (state_i == fake_sensor_pkg::IDLE))
		else $error("state not idle one cycle after stop");

endmodule

bind i2c_txn_execute fake_sensor_props u_props (
	.sys_clk  (sys_clk),
	.rst_n    (rst_n),
	.state_i  (state_q),
	.evt_i    (evt_i),
	.wb_req_i (wb_req_o),
	.wb_rsp_i (wb_rsp_i),
	.sda_oe_i (sda_oe_o)
);

//--- fake_sensor_stim.txt
# op dev reg b0 b1 ack, all hex; W writes b0 b1 from reg, R expects b0 b1 from reg
# ack is 1 when the target should acknowledge the first control byte
R 10 0000 10 A0 1
R 10 0001 A0 A1 1
R 10 000B B6 B7 1
W 10 0005 5A C3 1
R 10 0005 5A C3 1
W 10 0001 11 22 1
R 10 0001 A0 A1 1
W 10 3000 33 44 1
R 10 3000 09 56 1
R 10 3E9A 04 F7 1
R 10 0100 FF FF 1
W 22 0007 77 88 0
R 10 0007 B2 B3 1
R 22 0007 00 00 0
W 10 0000 22 99 1
W 10 0005 12 34 0
R 10 0000 00 00 0
R 22 0000 22 A0 1
R 22 0005 5A C3 1

//--- fake_sensor_top.sv
// Fake camera-sensor control port, an I2C target on sys_clk.
// sda_oe_o high means pull SDA low; the line is never driven high,
// so the board or testbench needs a pull-up on SDA.
// DEV_ADDR_RESET is the 7-bit address answered after reset.
`timescale 1ns/1ps
module fake_sensor_top #(
	parameter logic [fake_sensor_pkg::DEV_ADDR_W-1:0] DEV_ADDR_RESET = 7'h10
) (
	input  logic sys_clk,
	input  logic rst_n,
	input  logic scl_i,
	input  logic sda_i,
	output logic sda_oe_o
);

	fake_sensor_pkg::bus_evt_t              bus_evt;
	fake_sensor_pkg::wb_req_t               wb_req;
	fake_sensor_pkg::wb_rsp_t               wb_rsp;
	logic [fake_sensor_pkg::DEV_ADDR_W-1:0] dev_addr; // current target address

	i2c_bus_decode u_decode (
		.sys_clk (sys_clk),
		.rst_n   (rst_n),
		.scl_i   (scl_i),
		.sda_i   (sda_i),
		.evt_o   (bus_evt)
	);

	i2c_txn_execute u_execute (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.evt_i      (bus_evt),
		.dev_addr_i (dev_addr),
		.wb_req_o   (wb_req),
		.wb_rsp_i   (wb_rsp),
		.sda_oe_o   (sda_oe_o)
	);

	sensor_reg_result #(
		.DEV_ADDR_RESET (DEV_ADDR_RESET)
	) u_result (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.wb_req_i   (wb_req),
		.wb_rsp_o   (wb_rsp),
		.dev_addr_o (dev_addr)
	);

endmodule

//--- i2c_bus_decode.sv
// I2C bus front end. SCL and SDA are plain inputs sampled on sys_clk.
// Each SCL phase must last at least a dozen sys_clk cycles.
// Events lag the pins by 3 cycles and are single-cycle pulses.
// SDA is sampled once per synchronized SCL rising edge, no filtering.
`timescale 1ns/1ps
module i2c_bus_decode (
	input  logic                      sys_clk,
	input  logic                      rst_n,
	input  logic                      scl_i,
	input  logic                      sda_i,
	output fake_sensor_pkg::bus_evt_t evt_o
);

	localparam int CNT_W = $clog2(fake_sensor_pkg::DATA_W + 1);
	localparam logic [CNT_W-1:0] BIT_ACK  = CNT_W'(fake_sensor_pkg::DATA_W);
	localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(fake_sensor_pkg::DATA_W - 1);

	logic [2:0] scl_r; // two sync flops plus history
	logic [2:0] sda_r;
	logic       scl_rise;
	logic       scl_fall;
	logic       scl_high;
	logic       bus_start;
	logic       bus_stop;
	logic [CNT_W-1:0] bit_cnt;
	logic [fake_sensor_pkg::DATA_W-1:0] rx_shift;
	logic [fake_sensor_pkg::DATA_W-1:0] rx_byte_q;
	logic       start_q;
	logic       stop_q;
	logic       fall_q;
	logic       done_q;
	logic       ack_bit_q;
	logic       ack_vld_q;

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			scl_r <= '1; // idle bus is high
			sda_r <= '1;
		end else begin
			scl_r <= {scl_r[1:0], scl_i};
			sda_r <= {sda_r[1:0], sda_i};
		end
	end

	assign scl_rise  = scl_r[1] & ~scl_r[2];
	assign scl_fall  = ~scl_r[1] & scl_r[2];
	assign scl_high  = scl_r[1] & scl_r[2]; // stable high
	assign bus_start = scl_high & ~sda_r[1] & sda_r[2];
	assign bus_stop  = scl_high & sda_r[1] & ~sda_r[2];

	// event pulses and the bit counter
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			start_q   <= 1'b0;
			stop_q    <= 1'b0;
			fall_q    <= 1'b0;
			done_q    <= 1'b0;
			ack_vld_q <= 1'b0;
			bit_cnt   <= '0;
		end else begin
			start_q   <= bus_start;
			stop_q    <= bus_stop;
			fall_q    <= scl_fall;
			done_q    <= 1'b0;
			ack_vld_q <= 1'b0;
			if (bus_start || bus_stop) begin
				bit_cnt <= '0;
			end else if (scl_rise) begin
				if (bit_cnt == BIT_ACK) begin
					bit_cnt   <= '0; // ninth bit seen
					ack_vld_q <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + CNT_W'(1);
					done_q  <= (bit_cnt == BIT_LAST);
				end
			end
		end
	end

	// msb first shift, byte copy held for execute
	always_ff @(posedge sys_clk) begin
		if (scl_rise) begin
			if (bit_cnt == BIT_ACK) begin
				ack_bit_q <= sda_r[1];
			end else begin
				rx_shift <= {rx_shift[fake_sensor_pkg::DATA_W-2:0], sda_r[1]};
			end
			if (bit_cnt == BIT_LAST) begin
				rx_byte_q <= {rx_shift[fake_sensor_pkg::DATA_W-2:0], sda_r[1]};
			end
		end
	end

	always_comb begin
		evt_o.start     = start_q;
		evt_o.stop      = stop_q;
		evt_o.scl_fall  = fall_q;
		evt_o.byte_done = done_q;
		evt_o.ack_bit   = ack_bit_q;
		evt_o.ack_valid = ack_vld_q;
		evt_o.rx_byte   = rx_byte_q;
	end

endmodule

//--- i2c_txn_execute.sv
// Transaction engine of the I2C target.
// Expects a write control byte, two register address bytes high first,
// then data bytes; reads follow a read control byte, usually after Sr.
// sda_oe_o only ever pulls SDA low, set and cleared on SCL falls.
// Register accesses go out as Wishbone classic, one at a time.
// The register pointer steps after every completed access.
`timescale 1ns/1ps
module i2c_txn_execute (
	input  logic                                   sys_clk,
	input  logic                                   rst_n,
	input  fake_sensor_pkg::bus_evt_t              evt_i,
	input  logic [fake_sensor_pkg::DEV_ADDR_W-1:0] dev_addr_i,
	output fake_sensor_pkg::wb_req_t               wb_req_o,
	input  fake_sensor_pkg::wb_rsp_t               wb_rsp_i,
	output logic                                   sda_oe_o
);

	localparam int AW       = fake_sensor_pkg::REG_ADDR_W;
	localparam int DW       = fake_sensor_pkg::DATA_W;
	localparam int TX_IDX_W = $clog2(DW);

	fake_sensor_pkg::txn_state_e state_q;

	logic [AW-1:0]       reg_ptr_q;
	logic                ack_pend_q; // ack this byte on next scl fall
	logic                tx_arm_q;   // start shifting on next scl fall
	logic                tx_on_q;
	logic [TX_IDX_W-1:0] tx_idx_q;   // bit now on the line
	logic [TX_IDX_W-1:0] tx_nxt;
	logic                sda_oe_q;
	logic [DW-1:0]       rd_byte_q;
	logic                wb_cyc_q;
	logic                wb_we_q;
	logic [AW-1:0]       wb_adr_q;
	logic [DW-1:0]       wb_dat_q;
	logic                ctrl_hit;
	logic                ctrl_rd;
	logic                mst_slot;
	logic                rd_issue;
	logic                wr_issue;

	assign ctrl_hit = (evt_i.rx_byte[DW-1:1] == dev_addr_i);
	assign ctrl_rd  = (fake_sensor_pkg::i2c_dir_e'(evt_i.rx_byte[0]) == fake_sensor_pkg::DIR_READ);
	assign tx_nxt   = tx_idx_q - TX_IDX_W'(1);

	// ninth bit of a read byte, answered by the master
	assign mst_slot = (state_q == fake_sensor_pkg::READ) && !tx_on_q && !tx_arm_q && !ack_pend_q;

	assign rd_issue = (evt_i.byte_done && state_q == fake_sensor_pkg::CTRL && ctrl_hit && ctrl_rd)
		|| (mst_slot && evt_i.ack_valid && !evt_i.ack_bit);
	assign wr_issue = evt_i.byte_done && (state_q == fake_sensor_pkg::WRITE);

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			state_q    <= fake_sensor_pkg::IDLE;
			ack_pend_q <= 1'b0;
			tx_arm_q   <= 1'b0;
			tx_on_q    <= 1'b0;
			tx_idx_q   <= '0;
			sda_oe_q   <= 1'b0;
		end else if (evt_i.stop || evt_i.start) begin
			state_q    <= evt_i.stop ? fake_sensor_pkg::IDLE : fake_sensor_pkg::CTRL;
			ack_pend_q <= 1'b0; // release the line
			tx_arm_q   <= 1'b0;
			tx_on_q    <= 1'b0;
			sda_oe_q   <= 1'b0;
		end else begin
			if (evt_i.byte_done) begin
				case (state_q)
					fake_sensor_pkg::CTRL: begin
						if (ctrl_hit) begin
							ack_pend_q <= 1'b1;
							tx_arm_q   <= ctrl_rd; // first data byte after our ack
							state_q    <= ctrl_rd ? fake_sensor_pkg::READ : fake_sensor_pkg::ADDR_HI;
						end else begin
							state_q <= fake_sensor_pkg::WAIT_STOP; // not our address
						end
					end
					fake_sensor_pkg::ADDR_HI: begin
						ack_pend_q <= 1'b1;
						state_q    <= fake_sensor_pkg::ADDR_LO;
					end
					fake_sensor_pkg::ADDR_LO: begin
						ack_pend_q <= 1'b1;
						state_q    <= fake_sensor_pkg::WRITE;
					end
					fake_sensor_pkg::WRITE: ack_pend_q <= 1'b1;
					default: ;
				endcase
			end
			if (mst_slot && evt_i.ack_valid) begin
				if (evt_i.ack_bit) begin
					state_q <= fake_sensor_pkg::WAIT_STOP; // nack ends the read
				end else begin
					tx_arm_q <= 1'b1;
				end
			end
			if (evt_i.scl_fall) begin
				if (ack_pend_q) begin
					ack_pend_q <= 1'b0;
					sda_oe_q   <= 1'b1; // ack low for the ninth bit
				end else if (tx_arm_q) begin
					tx_arm_q <= 1'b0;
					tx_on_q  <= 1'b1;
					tx_idx_q <= '1;
					sda_oe_q <= ~rd_byte_q[DW-1];
				end else if (tx_on_q && tx_idx_q != '0) begin
					tx_idx_q <= tx_nxt;
					sda_oe_q <= ~rd_byte_q[tx_nxt];
				end else begin
					tx_on_q  <= 1'b0;
					sda_oe_q <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			reg_ptr_q <= '0;
		end else if (evt_i.byte_done && state_q == fake_sensor_pkg::ADDR_HI) begin
			reg_ptr_q[AW-1 -: DW] <= evt_i.rx_byte;
		end else if (evt_i.byte_done && state_q == fake_sensor_pkg::ADDR_LO) begin
			reg_ptr_q[DW-1:0] <= evt_i.rx_byte;
		end else if (wb_rsp_i.ack) begin
			reg_ptr_q <= reg_ptr_q + AW'(1); // auto increment
		end
	end

	// wishbone master, cyc and stb move together
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			wb_cyc_q <= 1'b0;
		end else if (wb_cyc_q) begin
			if (wb_rsp_i.ack) begin
				wb_cyc_q <= 1'b0;
			end
		end else if (rd_issue || wr_issue) begin
			wb_cyc_q <= 1'b1;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!wb_cyc_q && (rd_issue || wr_issue)) begin
			wb_we_q  <= wr_issue;
			wb_adr_q <= reg_ptr_q;
			wb_dat_q <= evt_i.rx_byte;
		end
		if (wb_cyc_q && wb_rsp_i.ack && !wb_we_q) begin
			rd_byte_q <= wb_rsp_i.dat;
		end
	end

	always_comb begin
		wb_req_o.cyc = wb_cyc_q;
		wb_req_o.stb = wb_cyc_q;
		wb_req_o.we  = wb_we_q;
		wb_req_o.adr = wb_adr_q;
		wb_req_o.dat = wb_dat_q;
	end

	assign sda_oe_o = sda_oe_q;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1
LOG=sim.log
verilator --binary --timing --assert -f fake_sensor.f --top-module tb_fake_sensor \
	-Mdir obj_dir -o tb_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > "$LOG" 2>&1
cat "$LOG"
grep -q "Errors found" "$LOG" && { echo "simulation failed"; exit 1; }
grep -q "No errors" "$LOG" || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
exit 0

//--- sensor_reg_result.sv
// Register map of the fake sensor, a Wishbone classic slave.
// Never stalls: ack comes the cycle after stb, for one cycle only.
// Address 0 holds the device address in its low 7 bits.
// Identity and sensor registers are constants; writes to them and to
// unmapped addresses are acknowledged and dropped.
`timescale 1ns/1ps
module sensor_reg_result #(
	parameter logic [fake_sensor_pkg::DEV_ADDR_W-1:0] DEV_ADDR_RESET = 7'h10
) (
	input  logic                                   sys_clk,
	input  logic                                   rst_n,
	input  fake_sensor_pkg::wb_req_t               wb_req_i,
	output fake_sensor_pkg::wb_rsp_t               wb_rsp_o,
	output logic [fake_sensor_pkg::DEV_ADDR_W-1:0] dev_addr_o
);

	localparam int AW       = fake_sensor_pkg::REG_ADDR_W;
	localparam int DW       = fake_sensor_pkg::DATA_W;
	localparam int RW_IDX_W = $clog2(fake_sensor_pkg::REG_RW_COUNT);

	logic [fake_sensor_pkg::DEV_ADDR_W-1:0] dev_addr_q;
	logic [DW-1:0] rw_mem_q [fake_sensor_pkg::REG_RW_COUNT];
	logic          ack_q;
	logic [DW-1:0] rdat_q;
	logic [DW-1:0] rd_val;
	logic [AW-1:0] id_off;
	logic [AW-1:0] rw_off;
	logic          dev_hit;
	logic          id_hit;
	logic          rw_hit;
	logic          access;
	logic          wr_en;

	assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q; // new request this cycle
	assign wr_en  = access && wb_req_i.we;

	always_comb begin
		id_off  = wb_req_i.adr - fake_sensor_pkg::REG_ID_BASE;
		rw_off  = wb_req_i.adr - fake_sensor_pkg::REG_RW_BASE;
		dev_hit = (wb_req_i.adr == fake_sensor_pkg::REG_DEV_ADDR);
		id_hit  = (id_off < fake_sensor_pkg::REG_ID_COUNT); // wraps below base
		rw_hit  = (rw_off < fake_sensor_pkg::REG_RW_COUNT);
		rd_val  = fake_sensor_pkg::READ_MISS_VAL;
		if (dev_hit) begin
			rd_val = {1'b0, dev_addr_q};
		end else if (id_hit) begin
			rd_val = fake_sensor_pkg::REG_ID_VAL + id_off[DW-1:0];
		end else if (rw_hit) begin
			rd_val = rw_mem_q[rw_off[RW_IDX_W-1:0]];
		end else begin
			for (int i = 0; i < fake_sensor_pkg::SENSOR_REG_COUNT; i++) begin
				if (wb_req_i.adr == fake_sensor_pkg::SENSOR_REG_ADDR[i]) begin
					rd_val = fake_sensor_pkg::SENSOR_REG_VAL[i];
				end
			end
		end
	end

	// writable state, reset values are part of the map
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			dev_addr_q <= DEV_ADDR_RESET;
			for (int i = 0; i < fake_sensor_pkg::REG_RW_COUNT; i++) begin
				rw_mem_q[i] <= fake_sensor_pkg::REG_RW_RESET + DW'(i);
			end
		end else if (wr_en) begin
			if (dev_hit) begin
				dev_addr_q <= wb_req_i.dat[fake_sensor_pkg::DEV_ADDR_W-1:0];
			end
			if (rw_hit) begin
				rw_mem_q[rw_off[RW_IDX_W-1:0]] <= wb_req_i.dat;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access; // one-cycle ack
		end
	end

	always_ff @(posedge sys_clk) begin
		if (access) begin
			rdat_q <= rd_val; // valid with ack
		end
	end

	always_comb begin
		wb_rsp_o.ack = ack_q;
		wb_rsp_o.dat = rdat_q;
	end

	assign dev_addr_o = dev_addr_q;

endmodule

//--- tb_fake_sensor.sv
// Testbench for the fake sensor I2C target, acting as the bus master.
// Transactions and expected bytes come from fake_sensor_stim.txt,
// opened relative to the directory the simulation runs in.
// Each SCL phase lasts 16 sys_clk cycles; SDA is open drain with a pull-up.
`timescale 1ns/1ps
module tb_fake_sensor;

	localparam int MAX_TESTS = 64;
	localparam int HALF      = 16; // sys_clk cycles per scl phase
	localparam int SETUP     = 4;  // sda moves this long after scl falls

	logic sys_clk;
	logic rst_n;
	logic m_scl;
	logic m_sda;
	logic sda_oe;
	logic sda_line;

	logic [7:0]  t_op  [MAX_TESTS];
	logic [6:0]  t_dev [MAX_TESTS];
	logic [15:0] t_reg [MAX_TESTS];
	logic [7:0]  t_b0  [MAX_TESTS];
	logic [7:0]  t_b1  [MAX_TESTS];
	logic        t_ack [MAX_TESTS];
	int          n_tests;
	logic        stim_loaded;
	logic        fail_shown;
	logic        run_passed;

	assign sda_line = m_sda && (sda_oe !== 1'b1); // target only pulls low

	fake_sensor_top #(
		.DEV_ADDR_RESET (7'h10)
	) DUT (
		.sys_clk  (sys_clk),
		.rst_n    (rst_n),
		.scl_i    (m_scl),
		.sda_i    (sda_line),
		.sda_oe_o (sda_oe)
	);

	initial begin
		sys_clk = 1'b0;
		forever #20 sys_clk = ~sys_clk;
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge sys_clk);
	endtask

	task automatic fail_run(input string msg);
		fail_shown = 1'b1;
		$display("%s", msg);
		$display("Errors found");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [15:0] exp_v,
			input logic [15:0] act_v);
		if (exp_v !== act_v) begin
			fail_run($sformatf("MISMATCH %s expected %h actual %h", name, exp_v, act_v));
		end
	endtask

	// bit tasks start and end just after scl is driven low
	task automatic send_bit(input logic b);
		wait_cycles(SETUP);
		m_sda <= b;
		wait_cycles(HALF - SETUP);
		m_scl <= 1'b1;
		wait_cycles(HALF);
		m_scl <= 1'b0;
	endtask

	task automatic recv_bit(output logic b);
		wait_cycles(SETUP);
		m_sda <= 1'b1; // release for the target
		wait_cycles(HALF - SETUP);
		m_scl <= 1'b1;
		wait_cycles(HALF / 2);
		@(negedge sys_clk);
		b = sda_line; // middle of the high phase
		wait_cycles(HALF / 2);
		m_scl <= 1'b0;
	endtask

	task automatic bus_start();
		wait_cycles(HALF);
		m_sda <= 1'b0; // sda falls with scl high
		wait_cycles(HALF);
		m_scl <= 1'b0;
	endtask

	task automatic bus_restart();
		wait_cycles(SETUP);
		m_sda <= 1'b1;
		wait_cycles(HALF - SETUP);
		m_scl <= 1'b1;
		wait_cycles(HALF);
		m_sda <= 1'b0;
		wait_cycles(HALF);
		m_scl <= 1'b0;
	endtask

	task automatic bus_stop();
		wait_cycles(SETUP);
		m_sda <= 1'b0;
		wait_cycles(HALF - SETUP);
		m_scl <= 1'b1;
		wait_cycles(HALF);
		m_sda <= 1'b1; // sda rises with scl high
		wait_cycles(HALF);
	endtask

	task automatic send_byte(input logic [7:0] data, output logic ack);
		logic b;
		for (int i = 7; i >= 0; i--) begin
			send_bit(data[i]);
		end
		recv_bit(b);
		ack = ~b;
	endtask

	task automatic recv_byte(input logic give_ack, output logic [7:0] data);
		logic b;
		for (int i = 7; i >= 0; i--) begin
			recv_bit(b);
			data[i] = b;
		end
		send_bit(~give_ack); // low means ack
	endtask

	task automatic run_write(input int i);
		string      tname;
		logic       ack;
		logic [7:0] wr_bytes [4];
		tname = $sformatf("line %0d W dev %02h reg %04h", i + 1, t_dev[i], t_reg[i]);
		wr_bytes = '{t_reg[i][15:8], t_reg[i][7:0], t_b0[i], t_b1[i]};
		bus_start();
		send_byte({t_dev[i], 1'b0}, ack);
		check_value({tname, " ctrl ack"}, 16'(t_ack[i]), 16'(ack));
		if (ack) begin
			for (int k = 0; k < 4; k++) begin
				send_byte(wr_bytes[k], ack);
				check_value($sformatf("%s byte %0d ack", tname, k), 16'd1, 16'(ack));
			end
		end
		bus_stop();
	endtask

	task automatic run_read(input int i);
		string      tname;
		logic       ack;
		logic [7:0] data;
		tname = $sformatf("line %0d R dev %02h reg %04h", i + 1, t_dev[i], t_reg[i]);
		bus_start();
		send_byte({t_dev[i], 1'b0}, ack);
		check_value({tname, " ctrl ack"}, 16'(t_ack[i]), 16'(ack));
		if (ack) begin
			send_byte(t_reg[i][15:8], ack);
			check_value({tname, " addr hi ack"}, 16'd1, 16'(ack));
			send_byte(t_reg[i][7:0], ack);
			check_value({tname, " addr lo ack"}, 16'd1, 16'(ack));
			bus_restart();
			send_byte({t_dev[i], 1'b1}, ack);
			check_value({tname, " read ctrl ack"}, 16'd1, 16'(ack));
			recv_byte(1'b1, data);
			check_value({tname, " byte 0"}, 16'(t_b0[i]), 16'(data));
			recv_byte(1'b0, data); // nack ends the read
			check_value({tname, " byte 1"}, 16'(t_b1[i]), 16'(data));
		end
		bus_stop();
	endtask

	task automatic load_stim();
		int              fd;
		int              code;
		int              nf;
		logic [8*96-1:0] line_buf;
		logic [31:0]     f_op;
		logic [15:0]     f_dev;
		logic [15:0]     f_reg;
		logic [15:0]     f_b0;
		logic [15:0]     f_b1;
		logic [15:0]     f_ack;
		fd = $fopen("fake_sensor_stim.txt", "r");
		if (fd == 0) begin
			fail_run("could not open fake_sensor_stim.txt");
		end else begin
			while (!$feof(fd)) begin
				line_buf = '0;
				code = $fgets(line_buf, fd);
				nf = $sscanf(line_buf, "%s %h %h %h %h %h", f_op, f_dev, f_reg, f_b0, f_b1,
					f_ack);
				// comment and blank lines fall out here
				if (code > 0 && nf == 6 && (f_op[7:0] == "W" || f_op[7:0] == "R")) begin
					if (n_tests == MAX_TESTS) begin
						fail_run("stim file holds more transactions than the testbench can store");
					end else begin
						t_op[n_tests]  = f_op[7:0];
						t_dev[n_tests] = f_dev[6:0];
						t_reg[n_tests] = f_reg;
						t_b0[n_tests]  = f_b0[7:0];
						t_b1[n_tests]  = f_b1[7:0];
						t_ack[n_tests] = f_ack[0];
						n_tests++;
					end
				end
			end
			$fclose(fd);
			if (n_tests == 0) begin
				fail_run("stim file holds no transactions");
			end else begin
				stim_loaded = 1'b1;
			end
		end
	endtask

	initial begin
		rst_n       = 1'b0;
		m_scl       = 1'b1;
		m_sda       = 1'b1;
		n_tests     = 0;
		stim_loaded = 1'b0;
		fail_shown  = 1'b0;
		run_passed  = 1'b0;
		load_stim();
		wait_cycles(4);
		rst_n <= 1'b1;
		wait_cycles(4);
		for (int i = 0; i < n_tests; i++) begin
			if (t_op[i] == "W") begin
				run_write(i);
			end else begin
				run_read(i);
			end
		end
		wait_cycles(HALF);
		run_passed = 1'b1;
		$display("No errors");
		$finish;
	end

	// watchdog, sized from the number of transactions
	initial begin
		longint limit_ns;
		wait (stim_loaded);
		limit_ns = longint'(n_tests) * 8 * 9 * 32 * 40 * 2; // bytes, bits, cycles, ns, margin
		#(limit_ns);
		fail_run($sformatf("timed out after %0d ns before all transactions finished", limit_ns));
	end

	// run stopped early, for example by a failed assertion
	final begin
		if (!run_passed && !fail_shown) begin
			$display("Errors found");
		end
	end

endmodule
